/* bench/renameUnitTb.sv */
// Testbench for the register rename unit
// Applies a table of rename, commit, flush and idle operations and checks
// the renamed register numbers and the stall and recovery flags

`timescale 1ns/100ps
`default_nettype none

module renameUnitTb;

    localparam int renameWidth = 2;
    localparam int commitWidth = 2;
    localparam int maxOps = 32;
    localparam int waitLimit = 50;

    localparam int opRename = 0;
    localparam int opCommit = 1;
    localparam int opFlush = 2;
    localparam int opIdle = 3;

    logic clk;
    logic rstN;
    logic flush;
    logic renameValid [renameWidth];
    logic writeReg [renameWidth];
    renameTypesPkg::lRegNum logSrcA [renameWidth];
    renameTypesPkg::lRegNum logSrcB [renameWidth];
    renameTypesPkg::lRegNum logDst [renameWidth];
    logic retireValid [commitWidth];
    renameTypesPkg::lRegNum retireLogDst [commitWidth];
    renameTypesPkg::pRegNum retirePhyDst [commitWidth];
    logic releaseValid [commitWidth];
    renameTypesPkg::pRegNum releaseReg [commitWidth];
    logic allocatable;
    logic recovering;
    renameTypesPkg::pRegNum phySrcA [renameWidth];
    renameTypesPkg::pRegNum phySrcB [renameWidth];
    renameTypesPkg::pRegNum phyDst [renameWidth];
    renameTypesPkg::pRegNum phyPrevDst [renameWidth];

    // Operation table, one control word and one expected word per slot
    string opName [maxOps];
    int opKind [maxOps];
    logic [15:0] opCtl [maxOps][renameWidth];
    logic [31:0] opExp [maxOps][renameWidth];
    int opCount;

    renameUnit #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) u_dut (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .renameValid(renameValid),
        .writeReg(writeReg),
        .logSrcA(logSrcA),
        .logSrcB(logSrcB),
        .logDst(logDst),
        .retireValid(retireValid),
        .retireLogDst(retireLogDst),
        .retirePhyDst(retirePhyDst),
        .releaseValid(releaseValid),
        .releaseReg(releaseReg),
        .allocatable(allocatable),
        .recovering(recovering),
        .phySrcA(phySrcA),
        .phySrcB(phySrcB),
        .phyDst(phyDst),
        .phyPrevDst(phyPrevDst)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic addOp(input string name, input int kind, input logic [15:0] ctl0,
                         input logic [31:0] exp0, input logic [15:0] ctl1,
                         input logic [31:0] exp1);
        opName[opCount] = name;
        opKind[opCount] = kind;
        opCtl[opCount][0] = ctl0;
        opExp[opCount][0] = exp0;
        opCtl[opCount][1] = ctl1;
        opExp[opCount][1] = exp1;
        opCount++;
    endtask

    task automatic clearInputs();
        flush = 1'b0;
        for (int i = 0; i < renameWidth; i++) begin
            renameValid[i] = 1'b0;
            writeReg[i] = 1'b0;
            logSrcA[i] = '0;
            logSrcB[i] = '0;
            logDst[i] = '0;
        end
        for (int c = 0; c < commitWidth; c++) begin
            retireValid[c] = 1'b0;
            retireLogDst[c] = '0;
            retirePhyDst[c] = '0;
            releaseValid[c] = 1'b0;
            releaseReg[c] = '0;
        end
    endtask

    // Rename ctl is {mode, srcA, srcB, dst}, mode 1 reads only, mode 3 also writes
    // Rename exp is {phyDst, phyPrevDst, phySrcA, phySrcB}, one byte each
    // Commit ctl mode bit 0 retires dst, bit 1 releases; exp is {retirePhy, releaseReg, 0, 0}
    // Idle exp0 holds recovering in bit 4 and allocatable in bit 0, flush exp0 the cycle count
    task automatic buildTable();
        opCount = 0;
        addOp("resetFlags", opIdle, 16'h0000, 32'h01, 16'h0000, 32'h00);
        addOp("resetSources", opRename, 16'h1370, 32'h00_00_03_07, 16'h0000, 32'h0);
        addOp("allocOrder", opRename, 16'h3124, 32'h10_04_01_02, 16'h3569, 32'h11_09_05_06);
        addOp("bypassSrc", opRename, 16'h3492, 32'h12_02_10_11, 16'h3203, 32'h13_03_12_00);
        addOp("sameDst", opRename, 16'h3327, 32'h14_07_13_12, 16'h3777, 32'h15_14_14_14);
        addOp("laterGroup", opRename, 16'h1740, 32'h00_00_15_10, 16'h0000, 32'h0);
        addOp("fill1", opRename, 16'h3aba, 32'h16_0a_0a_0b, 16'h3abb, 32'h17_0b_16_0b);
        addOp("fill2", opRename, 16'h3cdc, 32'h18_0c_0c_0d, 16'h3cdd, 32'h19_0d_18_0d);
        addOp("fill3", opRename, 16'h3efe, 32'h1a_0e_0e_0f, 16'h3eff, 32'h1b_0f_1a_0f);
        addOp("fill4", opRename, 16'h3bca, 32'h1c_16_17_18, 16'h3adb, 32'h1d_17_1c_19);
        addOp("fill5", opRename, 16'h3efc, 32'h1e_18_1a_1b, 16'h3c0d, 32'h1f_19_1e_00);
        addOp("emptyStall", opIdle, 16'h0000, 32'h00, 16'h0000, 32'h00);
        addOp("releaseTwo", opCommit, 16'h2000, 32'h00_09_00_00, 16'h2000, 32'h00_04_00_00);
        addOp("releaseVisible", opIdle, 16'h0000, 32'h01, 16'h0000, 32'h00);
        addOp("reuseOrder", opRename, 16'h3121, 32'h09_01_01_12, 16'h3155, 32'h04_05_09_05);
        addOp("retireSome", opCommit, 16'h3004, 32'h10_02_00_00, 16'h3009, 32'h11_03_00_00);
        addOp("retireMore", opCommit, 16'h3002, 32'h12_07_00_00, 16'h3007, 32'h15_14_00_00);
        addOp("specRename", opRename, 16'h3494, 32'h02_10_10_11, 16'h3479, 32'h03_11_02_15);
        addOp("flushCopy", opFlush, 16'h0000, 32'd8, 16'h0000, 32'h0);
        addOp("recoveredFlags", opIdle, 16'h0000, 32'h01, 16'h0000, 32'h00);
        addOp("readBack0", opRename, 16'h1010, 32'h00_00_00_01, 16'h1230, 32'h00_00_12_03);
        addOp("readBack1", opRename, 16'h1450, 32'h00_00_10_05, 16'h1670, 32'h00_00_06_15);
        addOp("readBack2", opRename, 16'h1890, 32'h00_00_08_11, 16'h1ab0, 32'h00_00_0a_0b);
        addOp("readBack3", opRename, 16'h1cd0, 32'h00_00_0c_0d, 16'h1ef0, 32'h00_00_0e_0f);
    endtask

    task automatic applyRename(input int idx);
        int waited;
        logic [15:0] ctl;
        logic [31:0] exp;
        waited = 0;
        // Hold the group until the stage can allocate
        while (!allocatable && waited < waitLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!allocatable) begin
            reportTimeout({opName[idx], ": allocatable never rose"});
        end
        for (int i = 0; i < renameWidth; i++) begin
            ctl = opCtl[idx][i];
            renameValid[i] = ctl[12];
            writeReg[i] = ctl[13];
            logSrcA[i] = ctl[11:8];
            logSrcB[i] = ctl[7:4];
            logDst[i] = ctl[3:0];
        end
        @(negedge clk);
        for (int i = 0; i < renameWidth; i++) begin
            ctl = opCtl[idx][i];
            exp = opExp[idx][i];
            if (ctl[12]) begin
                checkValue({opName[idx], " phySrcA"}, exp[15:8], phySrcA[i]);
                checkValue({opName[idx], " phySrcB"}, exp[7:0], phySrcB[i]);
                if (ctl[13]) begin
                    checkValue({opName[idx], " phyDst"}, exp[31:24], phyDst[i]);
                    checkValue({opName[idx], " phyPrevDst"}, exp[23:16], phyPrevDst[i]);
                end
            end
        end
    endtask

    task automatic applyCommit(input int idx);
        for (int c = 0; c < commitWidth; c++) begin
            retireValid[c] = opCtl[idx][c][12];
            retireLogDst[c] = opCtl[idx][c][3:0];
            retirePhyDst[c] = opExp[idx][c][28:24];
            releaseValid[c] = opCtl[idx][c][13];
            releaseReg[c] = opExp[idx][c][20:16];
        end
    endtask

    task automatic applyFlush(input int idx);
        int cycles;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        cycles = 0;
        // Count the cycles that recovering stays high, the stage must stall throughout
        while (recovering && cycles < waitLimit) begin
            checkValue({opName[idx], " allocatable"}, 0, allocatable);
            cycles++;
            @(posedge clk);
            #2;
        end
        if (recovering) begin
            reportTimeout({opName[idx], ": recovering never fell"});
        end
        checkValue({opName[idx], " recovery cycles"}, opExp[idx][0], cycles);
    endtask

    task automatic checkFlags(input int idx);
        checkValue({opName[idx], " allocatable"}, opExp[idx][0][0], allocatable);
        checkValue({opName[idx], " recovering"}, opExp[idx][0][4], recovering);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        clearInputs();
        buildTable();
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int k = 0; k < opCount; k++) begin
            @(posedge clk);
            #2;
            clearInputs();
            case (opKind[k])
                opRename: applyRename(k);
                opCommit: applyCommit(k);
                opFlush: applyFlush(k);
                default: checkFlags(k);
            endcase
        end
        @(posedge clk);
        #2;
        clearInputs();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : renameUnitTb

`default_nettype wire

/* bench/renameUnit_sva.sv */
// Protocol assertions for the rename unit
// Stall rule for rename requests, recovery length and free-list bound

`timescale 1ns/100ps
`default_nettype none

module renameUnitAssertions #(
    parameter int renameWidth = 2
) (
    input logic                     clk,
    input logic                     rstN,
    input logic                     flush,
    input logic                     renameValid [renameWidth],
    input logic                     allocatable,
    input logic                     recovering,
    input renameTypesPkg::freeCount freeListCount
);

    localparam int copySteps = renameTypesPkg::lRegCount / renameWidth;

    logic anyValid;

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < renameWidth; i++) begin
            anyValid = anyValid | renameValid[i];
        end
    end

    // No rename request while the stage is stalled
    noRenameWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        anyValid |-> allocatable)
        else $error("rename request while allocatable is low");

    // A flush from idle gives exactly one full copy pass
    recoveryLength: assert property (@(posedge clk) disable iff (!rstN)
        (flush && !recovering) |=> recovering [*copySteps] ##1 !recovering)
        else $error("recovering did not last the expected number of cycles");

    freeListBound: assert property (@(posedge clk) disable iff (!rstN)
        freeListCount <= renameTypesPkg::freeListSize)
        else $error("free-list count above its size");

endmodule : renameUnitAssertions

bind renameUnit renameUnitAssertions #(
    .renameWidth(renameWidth)
) u_checks (
    .clk(clk),
    .rstN(rstN),
    .flush(flush),
    .renameValid(renameValid),
    .allocatable(allocatable),
    .recovering(recovering),
    .freeListCount(freeListCount)
);

`default_nettype wire

/* design/freeList.sv */
// Free list of physical registers
// Circular buffer that hands out several registers and takes back several per cycle

`timescale 1ns/100ps
`default_nettype none

module freeList #(
    parameter int size = 16,
    parameter int popWidth = 2,
    parameter int pushWidth = 2
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     pop [popWidth],
    input  logic                     push [pushWidth],
    input  renameTypesPkg::pRegNum   pushedData [pushWidth],
    output renameTypesPkg::pRegNum   poppedData [popWidth],
    output renameTypesPkg::freeCount count
);

    localparam int ptrWidth = $clog2(size);

    renameTypesPkg::pRegNum entries [size];
    logic [ptrWidth-1:0] head;
    logic [ptrWidth-1:0] tail;
    logic [ptrWidth-1:0] popAddr [popWidth];
    logic [ptrWidth-1:0] pushAddr [pushWidth];
    int popTotal;
    int pushTotal;

    // Pointer advance with wrap, offset never exceeds size
    function automatic logic [ptrWidth-1:0] wrapAdd(
        input logic [ptrWidth-1:0] ptr,
        input int offset
    );
        int sum;
        sum = int'(ptr) + offset;
        if (sum >= size) begin
            sum = sum - size;
        end
        return ptrWidth'(sum);
    endfunction

    // Active pops take consecutive entries from the head
    always_comb begin
        popTotal = 0;
        for (int i = 0; i < popWidth; i++) begin
            popAddr[i] = wrapAdd(head, popTotal);
            poppedData[i] = entries[popAddr[i]];
            if (pop[i]) begin
                popTotal = popTotal + 1;
            end
        end
    end

    // Pushes are packed onto the tail in slot order
    always_comb begin
        pushTotal = 0;
        for (int c = 0; c < pushWidth; c++) begin
            pushAddr[c] = wrapAdd(tail, pushTotal);
            if (push[c]) begin
                pushTotal = pushTotal + 1;
            end
        end
    end

    // Reset fills the list with the registers above the identity map
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < size; i++) begin
                entries[i] <= renameTypesPkg::pRegNum'(renameTypesPkg::lRegCount + i);
            end
        end else begin
            for (int c = 0; c < pushWidth; c++) begin
                if (push[c]) begin
                    entries[pushAddr[c]] <= pushedData[c];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= renameTypesPkg::freeCount'(size);
        end else begin
            head <= wrapAdd(head, popTotal);
            tail <= wrapAdd(tail, pushTotal);
            count <= renameTypesPkg::freeCount'(int'(count) + pushTotal - popTotal);
        end
    end

endmodule : freeList

`default_nettype wire

/* design/renameCtrlPkg.sv */
// Recovery control definitions
// State encoding and step counter for the map-table recovery sequencer

`default_nettype none

package renameCtrlPkg;

    // Speculative map is either live or being restored from the retirement map
    typedef enum logic {
        recIdle,
        recCopying
    } recoveryState;

    // Width of the remaining-step counter
    localparam int recoveryStepCount = 4;

    typedef logic [recoveryStepCount-1:0] recoveryStep;

endpackage : renameCtrlPkg

`default_nettype wire

/* design/renameLogic.sv */
// Rename control
// Allocates and releases physical registers, bypasses within a rename group,
// drives map writes and restores the speculative map after a flush

`timescale 1ns/100ps
`default_nettype none

module renameLogic #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flush,
    input  logic                     renameValid [renameWidth],
    input  logic                     writeReg [renameWidth],
    input  renameTypesPkg::lRegNum   logSrcA [renameWidth],
    input  renameTypesPkg::lRegNum   logSrcB [renameWidth],
    input  renameTypesPkg::lRegNum   logDst [renameWidth],
    input  logic                     releaseValid [commitWidth],
    input  renameTypesPkg::pRegNum   releaseReg [commitWidth],
    input  renameTypesPkg::freeCount freeListCount,
    input  renameTypesPkg::pRegNum   poppedReg [renameWidth],
    input  renameTypesPkg::pRegNum   mapSrcAPhy [renameWidth],
    input  renameTypesPkg::pRegNum   mapSrcBPhy [renameWidth],
    input  renameTypesPkg::pRegNum   mapDstPhy [renameWidth],
    input  renameTypesPkg::pRegNum   retireReadPhy [renameWidth],
    output logic                     allocatable,
    output logic                     recovering,
    output logic                     pop [renameWidth],
    output logic                     push [commitWidth],
    output renameTypesPkg::pRegNum   pushedReg [commitWidth],
    output renameTypesPkg::pRegNum   phySrcA [renameWidth],
    output renameTypesPkg::pRegNum   phySrcB [renameWidth],
    output renameTypesPkg::pRegNum   phyDst [renameWidth],
    output renameTypesPkg::pRegNum   phyPrevDst [renameWidth],
    output logic                     mapWrite [renameWidth],
    output renameTypesPkg::lRegNum   mapWriteLog [renameWidth],
    output renameTypesPkg::pRegNum   mapWritePhy [renameWidth],
    output renameTypesPkg::lRegNum   retireReadLog [renameWidth]
);

    // Cycles needed to copy the whole retirement map
    localparam int copySteps = renameTypesPkg::lRegCount / renameWidth;

    renameCtrlPkg::recoveryState state;
    renameCtrlPkg::recoveryStep stepsLeft;
    renameTypesPkg::lRegNum recoveryIndex;
    logic anyRename;

    assign recovering = (state == renameCtrlPkg::recCopying);

    // Front end stalls during recovery or when a full group cannot be served
    assign allocatable = !recovering && (int'(freeListCount) >= renameWidth);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= renameCtrlPkg::recIdle;
            stepsLeft <= '0;
            recoveryIndex <= '0;
        end else if (flush) begin
            state <= renameCtrlPkg::recCopying;
            stepsLeft <= renameCtrlPkg::recoveryStep'(copySteps - 1);
            recoveryIndex <= '0;
        end else if (recovering) begin
            recoveryIndex <= recoveryIndex + renameTypesPkg::lRegNum'(renameWidth);
            if (stepsLeft == '0) begin
                state <= renameCtrlPkg::recIdle;
            end else begin
                stepsLeft <= stepsLeft - 1'b1;
            end
        end
    end

    // Released registers go straight to the free-list tail
    always_comb begin
        for (int c = 0; c < commitWidth; c++) begin
            push[c] = releaseValid[c];
            pushedReg[c] = releaseReg[c];
        end
    end

    always_comb begin
        anyRename = 1'b0;
        for (int i = 0; i < renameWidth; i++) begin
            pop[i] = renameValid[i] && writeReg[i];
            anyRename = anyRename | renameValid[i];
            phyDst[i] = poppedReg[i];
            phySrcA[i] = mapSrcAPhy[i];
            phySrcB[i] = mapSrcBPhy[i];
            phyPrevDst[i] = mapDstPhy[i];
            // Youngest earlier writer of the same register overrides the map
            for (int j = 0; j < i; j++) begin
                if (pop[j] && logDst[j] == logSrcA[i]) begin
                    phySrcA[i] = poppedReg[j];
                end
                if (pop[j] && logDst[j] == logSrcB[i]) begin
                    phySrcB[i] = poppedReg[j];
                end
                if (pop[j] && logDst[j] == logDst[i]) begin
                    phyPrevDst[i] = poppedReg[j];
                end
            end
            retireReadLog[i] = recoveryIndex + renameTypesPkg::lRegNum'(i);
        end

        // Rename writes have priority, otherwise copy from the retirement map
        for (int i = 0; i < renameWidth; i++) begin
            if (anyRename) begin
                mapWrite[i] = pop[i];
                mapWriteLog[i] = logDst[i];
                mapWritePhy[i] = poppedReg[i];
            end else begin
                mapWrite[i] = recovering;
                mapWriteLog[i] = retireReadLog[i];
                mapWritePhy[i] = retireReadPhy[i];
            end
        end
    end

endmodule : renameLogic

`default_nettype wire

/* design/renameMapTable.sv */
// Speculative rename map table
// Logical to physical mapping with source and destination read ports

`timescale 1ns/100ps
`default_nettype none

module renameMapTable #(
    parameter int readWidth = 2,
    parameter int writeWidth = 2
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  renameTypesPkg::lRegNum readSrcA [readWidth],
    input  renameTypesPkg::lRegNum readSrcB [readWidth],
    input  renameTypesPkg::lRegNum readDst [readWidth],
    input  logic                   write [writeWidth],
    input  renameTypesPkg::lRegNum writeLog [writeWidth],
    input  renameTypesPkg::pRegNum writePhy [writeWidth],
    output renameTypesPkg::pRegNum srcAPhy [readWidth],
    output renameTypesPkg::pRegNum srcBPhy [readWidth],
    output renameTypesPkg::pRegNum dstPhy [readWidth]
);

    renameTypesPkg::pRegNum mapping [renameTypesPkg::lRegCount];

    // Reads see the table as it was before this edge
    always_comb begin
        for (int i = 0; i < readWidth; i++) begin
            srcAPhy[i] = mapping[readSrcA[i]];
            srcBPhy[i] = mapping[readSrcB[i]];
            dstPhy[i] = mapping[readDst[i]];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // Identity map
            for (int r = 0; r < renameTypesPkg::lRegCount; r++) begin
                mapping[r] <= renameTypesPkg::pRegNum'(r);
            end
        end else begin
            // Ascending loop, so the highest port wins a conflict
            for (int w = 0; w < writeWidth; w++) begin
                if (write[w]) begin
                    mapping[writeLog[w]] <= writePhy[w];
                end
            end
        end
    end

endmodule : renameMapTable

`default_nettype wire

/* design/renameTypesPkg.sv */
// Register numbering for the rename block
// Logical and physical register numbers, free-list sizing and occupancy type

`default_nettype none

package renameTypesPkg;

    // Architectural and physical register file sizes
    localparam int lRegCount = 16;
    localparam int pRegCount = 32;

    // Registers not held by the identity map start out free
    localparam int freeListSize = pRegCount - lRegCount;

    // Logical register number, 16 registers
    typedef logic [3:0] lRegNum;

    // Physical register number, 32 registers
    typedef logic [4:0] pRegNum;

    // Free-list occupancy, 0 up to freeListSize
    typedef logic [4:0] freeCount;

endpackage : renameTypesPkg

`default_nettype wire

/* design/renameUnit.sv */
// Register rename unit
// Free list, speculative and retirement map tables and their control

`timescale 1ns/100ps
`default_nettype none

module renameUnit #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   flush,
    input  logic                   renameValid [renameWidth],
    input  logic                   writeReg [renameWidth],
    input  renameTypesPkg::lRegNum logSrcA [renameWidth],
    input  renameTypesPkg::lRegNum logSrcB [renameWidth],
    input  renameTypesPkg::lRegNum logDst [renameWidth],
    input  logic                   retireValid [commitWidth],
    input  renameTypesPkg::lRegNum retireLogDst [commitWidth],
    input  renameTypesPkg::pRegNum retirePhyDst [commitWidth],
    input  logic                   releaseValid [commitWidth],
    input  renameTypesPkg::pRegNum releaseReg [commitWidth],
    output logic                   allocatable,
    output logic                   recovering,
    output renameTypesPkg::pRegNum phySrcA [renameWidth],
    output renameTypesPkg::pRegNum phySrcB [renameWidth],
    output renameTypesPkg::pRegNum phyDst [renameWidth],
    output renameTypesPkg::pRegNum phyPrevDst [renameWidth]
);

    logic pop [renameWidth];
    logic push [commitWidth];
    renameTypesPkg::pRegNum pushedReg [commitWidth];
    renameTypesPkg::pRegNum poppedReg [renameWidth];
    renameTypesPkg::freeCount freeListCount;
    renameTypesPkg::pRegNum mapSrcAPhy [renameWidth];
    renameTypesPkg::pRegNum mapSrcBPhy [renameWidth];
    renameTypesPkg::pRegNum mapDstPhy [renameWidth];
    logic mapWrite [renameWidth];
    renameTypesPkg::lRegNum mapWriteLog [renameWidth];
    renameTypesPkg::pRegNum mapWritePhy [renameWidth];
    renameTypesPkg::lRegNum retireReadLog [renameWidth];
    renameTypesPkg::pRegNum retireReadPhy [renameWidth];

    freeList #(
        .size(renameTypesPkg::freeListSize),
        .popWidth(renameWidth),
        .pushWidth(commitWidth)
    ) regFreeList (
        .clk(clk),
        .rstN(rstN),
        .pop(pop),
        .push(push),
        .pushedData(pushedReg),
        .poppedData(poppedReg),
        .count(freeListCount)
    );

    renameMapTable #(
        .readWidth(renameWidth),
        .writeWidth(renameWidth)
    ) specMap (
        .clk(clk),
        .rstN(rstN),
        .readSrcA(logSrcA),
        .readSrcB(logSrcB),
        .readDst(logDst),
        .write(mapWrite),
        .writeLog(mapWriteLog),
        .writePhy(mapWritePhy),
        .srcAPhy(mapSrcAPhy),
        .srcBPhy(mapSrcBPhy),
        .dstPhy(mapDstPhy)
    );

    retireMapTable #(
        .commitWidth(commitWidth),
        .readWidth(renameWidth)
    ) retireMap (
        .clk(clk),
        .rstN(rstN),
        .retireValid(retireValid),
        .retireLogDst(retireLogDst),
        .retirePhyDst(retirePhyDst),
        .readLog(retireReadLog),
        .readPhy(retireReadPhy)
    );

    renameLogic #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) renameCtrl (
        .clk(clk),
        .rstN(rstN),
        .flush(flush),
        .renameValid(renameValid),
        .writeReg(writeReg),
        .logSrcA(logSrcA),
        .logSrcB(logSrcB),
        .logDst(logDst),
        .releaseValid(releaseValid),
        .releaseReg(releaseReg),
        .freeListCount(freeListCount),
        .poppedReg(poppedReg),
        .mapSrcAPhy(mapSrcAPhy),
        .mapSrcBPhy(mapSrcBPhy),
        .mapDstPhy(mapDstPhy),
        .retireReadPhy(retireReadPhy),
        .allocatable(allocatable),
        .recovering(recovering),
        .pop(pop),
        .push(push),
        .pushedReg(pushedReg),
        .phySrcA(phySrcA),
        .phySrcB(phySrcB),
        .phyDst(phyDst),
        .phyPrevDst(phyPrevDst),
        .mapWrite(mapWrite),
        .mapWriteLog(mapWriteLog),
        .mapWritePhy(mapWritePhy),
        .retireReadLog(retireReadLog)
    );

endmodule : renameUnit

`default_nettype wire

/* design/retireMapTable.sv */
// Retirement rename map table
// Committed mapping, written at retire and read back during recovery

`timescale 1ns/100ps
`default_nettype none

module retireMapTable #(
    parameter int commitWidth = 2,
    parameter int readWidth = 2
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   retireValid [commitWidth],
    input  renameTypesPkg::lRegNum retireLogDst [commitWidth],
    input  renameTypesPkg::pRegNum retirePhyDst [commitWidth],
    input  renameTypesPkg::lRegNum readLog [readWidth],
    output renameTypesPkg::pRegNum readPhy [readWidth]
);

    renameTypesPkg::pRegNum mapping [renameTypesPkg::lRegCount];

    always_comb begin
        for (int i = 0; i < readWidth; i++) begin
            readPhy[i] = mapping[readLog[i]];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int r = 0; r < renameTypesPkg::lRegCount; r++) begin
                mapping[r] <= renameTypesPkg::pRegNum'(r);
            end
        end else begin
            // Younger retire slot wins when two commit the same register
            for (int c = 0; c < commitWidth; c++) begin
                if (retireValid[c]) begin
                    mapping[retireLogDst[c]] <= retirePhyDst[c];
                end
            end
        end
    end

endmodule : retireMapTable

`default_nettype wire

/* project.f */
design/renameTypesPkg.sv
design/renameCtrlPkg.sv
design/freeList.sv
design/renameMapTable.sv
design/retireMapTable.sv
design/renameLogic.sv
design/renameUnit.sv
bench/renameUnit_sva.sv
bench/renameUnitTb.sv
